/* include/ccu_macros.svh */
`ifndef CCU_MACROS_SVH
`define CCU_MACROS_SVH

// Bus and cache line geometry
`define CCU_DATA_W      64
`define CCU_STRB_W      (`CCU_DATA_W / 8)
`define CCU_LINE_W      128
`define CCU_LINE_BEATS  (`CCU_LINE_W / `CCU_DATA_W)
`define CCU_LINE_OFF_W  $clog2(`CCU_LINE_W / 8)
`define CCU_ADDR_W      32

// Core-side ID and controller ports
`define CCU_ID_W        4
`define CCU_NUM_CTRL    2
`define CCU_CTRL_IDX_W  $clog2(`CCU_NUM_CTRL)

// Memory-side ID is writeback flag, responder index, core ID
`define CCU_MEM_ID_W    (1 + `CCU_CTRL_IDX_W + `CCU_ID_W)

`endif

/* hw/ccu_axi_pkg.sv */
`default_nettype none
`include "ccu_macros.svh"

package ccu_axi_pkg;

    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef logic [`CCU_DATA_W-1:0] data_t;

    typedef struct packed {
        logic [`CCU_MEM_ID_W-1:0] id;
        logic [`CCU_ADDR_W-1:0]   addr;
        logic [7:0]               len;
        logic [2:0]               size;
        logic [1:0]               burst;
        logic                     lock;
        logic [5:0]               atop;
    } aw_chan_t;

    typedef struct packed {
        logic [`CCU_MEM_ID_W-1:0] id;
        logic [`CCU_ADDR_W-1:0]   addr;
        logic [7:0]               len;
        logic [2:0]               size;
        logic [1:0]               burst;
        logic                     lock;
    } ar_chan_t;

    typedef struct packed {
        data_t                  data;
        logic [`CCU_STRB_W-1:0] strb;
        logic                   last;
    } w_chan_t;

    typedef struct packed {
        logic [`CCU_MEM_ID_W-1:0] id;
        logic [1:0]               resp;
    } b_chan_t;

    typedef struct packed {
        logic [`CCU_MEM_ID_W-1:0] id;
        data_t                    data;
        logic [1:0]               resp;
        logic                     last;
    } r_chan_t;

    // Same bundle on core and memory side
    typedef struct packed {
        aw_chan_t aw;
        logic     aw_valid;
        w_chan_t  w;
        logic     w_valid;
        logic     b_ready;
        ar_chan_t ar;
        logic     ar_valid;
        logic     r_ready;
    } axi_req_t;

    typedef struct packed {
        logic     aw_ready;
        logic     w_ready;
        b_chan_t  b;
        logic     b_valid;
        logic     ar_ready;
        r_chan_t  r;
        logic     r_valid;
    } axi_resp_t;

endpackage

`default_nettype wire

/* hw/ccu_ctrl_pkg.sv */
`default_nettype none
`include "ccu_macros.svh"

package ccu_ctrl_pkg;

    // Wait states are entered internally only
    typedef enum logic [2:0] {
        SEND_R,
        SEND_WB_R,
        SEND_W,
        SEND_WB_W,
        AMO_WAIT_WB_R,
        AMO_WAIT_WB_W
    } mu_op_e;

    typedef struct packed {
        mu_op_e                     op;
        ccu_axi_pkg::ar_chan_t      ar;
        ccu_axi_pkg::aw_chan_t      aw;
        logic [`CCU_CTRL_IDX_W-1:0] first_resp;
    } mu_cmd_t;

    // Source of the next W burst on the memory bus
    typedef enum logic {
        W_CORE,
        W_SNOOP
    } w_src_e;

endpackage

`default_nettype wire

/* hw/ccu_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module ccu_fifo #(
    parameter int unsigned Depth = 4,
    parameter type         payload_t = logic
) (
    input  wire logic     clk_i,
    input  wire logic     rst_ni,
    input  wire logic     push_i,
    input  wire payload_t data_i,
    input  wire logic     pop_i,
    output payload_t      data_o,
    output logic          full_o,
    output logic          empty_o
);

    localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int unsigned CntW = $clog2(Depth + 1);

    payload_t        mem_q [Depth];
    logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0] count_q;
    logic            do_push, do_pop;

    function automatic logic [PtrW-1:0] next_ptr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(Depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CntW'(Depth));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Producer and consumer must respect the flags
    assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o);
    assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* hw/ccu_mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ccu_macros.svh"

module ccu_mem_arbiter (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic [`CCU_NUM_CTRL-1:0] req_i,
    input  wire ccu_ctrl_pkg::mu_cmd_t    cmd_i [`CCU_NUM_CTRL],
    output logic [`CCU_NUM_CTRL-1:0]      gnt_o,
    output logic                          mu_req_o,
    output ccu_ctrl_pkg::mu_cmd_t         mu_cmd_o,
    input  wire logic                     mu_gnt_i
);

    localparam int unsigned NumCtrl = `CCU_NUM_CTRL;
    localparam int unsigned IdxW    = `CCU_CTRL_IDX_W;

    logic [IdxW-1:0] rr_q, rr_d, sel;
    logic            found;

    // First requester at or after the pointer
    always_comb begin
        int unsigned idx;
        sel   = rr_q;
        found = 1'b0;
        for (int unsigned i = 0; i < NumCtrl; i++) begin
            idx = (rr_q + i) % NumCtrl;
            if (!found && req_i[idx]) begin
                sel   = IdxW'(idx);
                found = 1'b1;
            end
        end
    end

    assign mu_req_o = found;
    assign mu_cmd_o = cmd_i[sel];

    always_comb begin
        gnt_o      = '0;
        gnt_o[sel] = mu_gnt_i;
    end

    always_comb begin
        rr_d = rr_q;
        if (mu_req_o && mu_gnt_i) begin
            rr_d = (sel == IdxW'(NumCtrl - 1)) ? '0 : sel + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rr_q <= '0;
        end else begin
            rr_q <= rr_d;
        end
    end

    // A grant only ever reaches one port that is asking
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0));

endmodule

`default_nettype wire

/* hw/ccu_mem_unit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ccu_macros.svh"

module ccu_mem_unit (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire logic                   mu_req_i,
    input  wire ccu_ctrl_pkg::mu_cmd_t  mu_cmd_i,
    output logic                        mu_gnt_o,
    input  wire ccu_axi_pkg::axi_req_t  core_req_i,
    output ccu_axi_pkg::axi_resp_t      core_resp_o,
    output ccu_axi_pkg::axi_req_t       mem_req_o,
    input  wire ccu_axi_pkg::axi_resp_t mem_resp_i,
    input  wire logic [`CCU_DATA_W-1:0] cd_data_i,
    input  wire logic                   cd_push_i,
    output logic                        cd_full_o
);
    import ccu_axi_pkg::*;
    import ccu_ctrl_pkg::*;

    localparam int unsigned CdDepth   = 4;
    localparam int unsigned TagDepth  = 2;
    localparam int unsigned LineBeats = `CCU_LINE_BEATS;
    localparam int unsigned BeatW     = (LineBeats > 1) ? $clog2(LineBeats) : 1;
    localparam int unsigned WbFlagBit = `CCU_MEM_ID_W - 1;

    logic    busy_q, busy_d;
    mu_op_e  op_q, op_d, op_cur;
    mu_cmd_t cmd_q, cmd;

    aw_chan_t                 aw, wb_aw;
    ar_chan_t                 ar;
    logic                     aw_valid, ar_valid;
    logic                     wb_src_ar, wb_b_hit;
    logic [`CCU_ADDR_W-1:0]   wb_addr;
    logic [`CCU_ID_W-1:0]     wb_core_id;
    logic [`CCU_MEM_ID_W-1:0] wb_id;

    w_src_e tag_in, tag_out;
    logic   tag_push, tag_pop, tag_full, tag_empty;

    data_t cd_data;
    logic  cd_pop, cd_empty;

    w_chan_t          mem_w;
    logic             mem_w_valid, core_w_ready;
    logic [BeatW-1:0] beat_q, beat_d;
    logic             snoop_last, is_wb_b;

    assign mu_gnt_o = !busy_q && mu_req_i;
    assign cmd      = busy_q ? cmd_q : mu_cmd_i;
    assign op_cur   = busy_q ? op_q : mu_cmd_i.op;

    always_ff @(posedge clk_i) begin
        if (mu_gnt_o) begin
            cmd_q <= mu_cmd_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
            op_q   <= SEND_R;
            beat_q <= '0;
        end else begin
            busy_q <= busy_d;
            op_q   <= op_d;
            beat_q <= beat_d;
        end
    end

    // Writeback AW covers the whole line the request falls in
    assign wb_src_ar  = (op_cur == SEND_WB_R) || (op_cur == AMO_WAIT_WB_R);
    assign wb_addr    = wb_src_ar ? cmd.ar.addr : cmd.aw.addr;
    assign wb_core_id = wb_src_ar ? cmd.ar.id[`CCU_ID_W-1:0] : cmd.aw.id[`CCU_ID_W-1:0];
    assign wb_id      = {1'b1, cmd.first_resp, wb_core_id};
    assign wb_b_hit   = mem_resp_i.b_valid && (mem_resp_i.b.id == wb_id);

    always_comb begin
        wb_aw       = '0;
        wb_aw.id    = wb_id;
        wb_aw.addr  = wb_addr;
        wb_aw.addr[`CCU_LINE_OFF_W-1:0] = '0;
        wb_aw.len   = 8'(LineBeats - 1);
        wb_aw.size  = 3'($clog2(`CCU_DATA_W / 8));
        wb_aw.burst = BURST_INCR;
    end

    always_comb begin
        busy_d   = busy_q;
        op_d     = op_q;
        ar       = '0;
        aw       = '0;
        ar_valid = 1'b0;
        aw_valid = 1'b0;
        tag_push = 1'b0;
        tag_in   = W_CORE;

        if (mu_gnt_o || busy_q) begin
            busy_d = 1'b1;
            op_d   = op_cur;
            case (op_cur)
                SEND_R: begin
                    ar_valid = 1'b1;
                    ar       = cmd.ar;
                    if (mem_resp_i.ar_ready) begin
                        busy_d = 1'b0;
                    end
                end
                SEND_W: begin
                    aw_valid = !tag_full;
                    aw       = cmd.aw;
                    if (mem_resp_i.aw_ready && !tag_full) begin
                        tag_push = 1'b1;
                        busy_d   = 1'b0;
                    end
                end
                SEND_WB_R: begin
                    aw_valid = !tag_full;
                    aw       = wb_aw;
                    tag_in   = W_SNOOP;
                    if (mem_resp_i.aw_ready && !tag_full) begin
                        tag_push = 1'b1;
                        if (cmd.ar.lock) begin
                            op_d = AMO_WAIT_WB_R;
                        end else begin
                            busy_d = 1'b0;
                        end
                    end
                end
                SEND_WB_W: begin
                    aw_valid = !tag_full;
                    aw       = wb_aw;
                    tag_in   = W_SNOOP;
                    if (mem_resp_i.aw_ready && !tag_full) begin
                        tag_push = 1'b1;
                        op_d     = cmd.aw.atop[5] ? AMO_WAIT_WB_W : SEND_W;
                    end
                end
                AMO_WAIT_WB_R: begin
                    if (wb_b_hit) begin
                        op_d = SEND_R;
                    end
                end
                AMO_WAIT_WB_W: begin
                    if (wb_b_hit) begin
                        op_d = SEND_W;
                    end
                end
                default: begin
                    busy_d = 1'b0;
                end
            endcase
        end
    end

    ccu_fifo #(
        .Depth     (CdDepth),
        .payload_t (data_t)
    ) cd_fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (cd_push_i),
        .data_i  (cd_data_i),
        .pop_i   (cd_pop),
        .data_o  (cd_data),
        .full_o  (cd_full_o),
        .empty_o (cd_empty)
    );

    ccu_fifo #(
        .Depth     (TagDepth),
        .payload_t (w_src_e)
    ) tag_fifo_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .push_i  (tag_push),
        .data_i  (tag_in),
        .pop_i   (tag_pop),
        .data_o  (tag_out),
        .full_o  (tag_full),
        .empty_o (tag_empty)
    );

    // W bursts leave in the order their AWs were accepted
    assign snoop_last = (beat_q == BeatW'(LineBeats - 1));

    always_comb begin
        mem_w        = core_req_i.w;
        mem_w_valid  = 1'b0;
        core_w_ready = 1'b0;
        tag_pop      = 1'b0;
        cd_pop       = 1'b0;
        beat_d       = beat_q;

        if (!tag_empty) begin
            if (tag_out == W_CORE) begin
                mem_w_valid  = core_req_i.w_valid;
                core_w_ready = mem_resp_i.w_ready;
                tag_pop      = core_req_i.w_valid && mem_resp_i.w_ready && core_req_i.w.last;
            end else begin
                mem_w_valid = !cd_empty;
                mem_w.data  = cd_data;
                mem_w.strb  = '1;
                mem_w.last  = snoop_last;
                if (!cd_empty && mem_resp_i.w_ready) begin
                    cd_pop  = 1'b1;
                    tag_pop = snoop_last;
                    beat_d  = snoop_last ? '0 : beat_q + 1'b1;
                end
            end
        end
    end

    // Writeback responses are absorbed here
    assign is_wb_b = mem_resp_i.b.id[WbFlagBit];

    always_comb begin
        mem_req_o          = '0;
        mem_req_o.aw       = aw;
        mem_req_o.aw_valid = aw_valid;
        mem_req_o.w        = mem_w;
        mem_req_o.w_valid  = mem_w_valid;
        mem_req_o.b_ready  = is_wb_b || core_req_i.b_ready;
        mem_req_o.ar       = ar;
        mem_req_o.ar_valid = ar_valid;
        mem_req_o.r_ready  = core_req_i.r_ready;

        // Core addresses arrive through the controller commands
        core_resp_o         = '0;
        core_resp_o.w_ready = core_w_ready;
        core_resp_o.b       = mem_resp_i.b;
        core_resp_o.b_valid = mem_resp_i.b_valid && !is_wb_b;
        core_resp_o.r       = mem_resp_i.r;
        core_resp_o.r_valid = mem_resp_i.r_valid;
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.aw_valid && !mem_resp_i.aw_ready
        |=> mem_req_o.aw_valid && $stable(mem_req_o.aw));

endmodule

`default_nettype wire

/* hw/ccu_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ccu_macros.svh"

module ccu_mem_top (
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire logic [`CCU_NUM_CTRL-1:0] mu_req_i,
    input  wire ccu_ctrl_pkg::mu_cmd_t    mu_cmd_i [`CCU_NUM_CTRL],
    output logic [`CCU_NUM_CTRL-1:0]      mu_gnt_o,
    input  wire ccu_axi_pkg::axi_req_t    core_req_i,
    output ccu_axi_pkg::axi_resp_t        core_resp_o,
    output ccu_axi_pkg::axi_req_t         mem_req_o,
    input  wire ccu_axi_pkg::axi_resp_t   mem_resp_i,
    input  wire logic [`CCU_DATA_W-1:0]   cd_data_i,
    input  wire logic                     cd_push_i,
    output logic                          cd_full_o
);
    import ccu_ctrl_pkg::*;

    logic    mu_req;
    mu_cmd_t mu_cmd;
    logic    mu_gnt;

    ccu_mem_arbiter arbiter_i (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (mu_req_i),
        .cmd_i    (mu_cmd_i),
        .gnt_o    (mu_gnt_o),
        .mu_req_o (mu_req),
        .mu_cmd_o (mu_cmd),
        .mu_gnt_i (mu_gnt)
    );

    ccu_mem_unit mem_unit_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mu_req_i    (mu_req),
        .mu_cmd_i    (mu_cmd),
        .mu_gnt_o    (mu_gnt),
        .core_req_i  (core_req_i),
        .core_resp_o (core_resp_o),
        .mem_req_o   (mem_req_o),
        .mem_resp_i  (mem_resp_i),
        .cd_data_i   (cd_data_i),
        .cd_push_i   (cd_push_i),
        .cd_full_o   (cd_full_o)
    );

endmodule

`default_nettype wire

/* bench/ccu_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ccu_macros.svh"

module ccu_mem_tb;
    import ccu_axi_pkg::*;
    import ccu_ctrl_pkg::*;

    localparam int unsigned NumCtrl     = `CCU_NUM_CTRL;
    localparam int unsigned IdxW        = `CCU_CTRL_IDX_W;
    localparam int unsigned MemIdW      = `CCU_MEM_ID_W;
    localparam int unsigned WbFlagBit   = MemIdW - 1;
    localparam int unsigned ResetCycles = 16;
    localparam int unsigned CmdsPerPort = 24;
    localparam int unsigned NumCmds     = CmdsPerPort * NumCtrl;
    localparam int unsigned Timeout     = NumCmds * 40 + ResetCycles;
    localparam logic [31:0] Seed        = 32'h01218153;

    typedef struct packed {
        logic     is_aw;
        logic     blocks;
        aw_chan_t aw;
        ar_chan_t ar;
    } addr_item_t;

    // Up to two address handshakes per command
    typedef struct packed {
        logic [1:0] n;
        addr_item_t first;
        addr_item_t second;
    } addr_exp_t;

    typedef struct packed {
        data_t wdata;
        data_t snoop0;
        data_t snoop1;
    } port_data_t;

    logic                 clk_i = 1'b0;
    logic                 rst_ni;
    logic [NumCtrl-1:0]   mu_req;
    mu_cmd_t              mu_cmd [NumCtrl];
    logic [NumCtrl-1:0]   mu_gnt;
    axi_req_t             core_req;
    axi_resp_t            core_resp;
    axi_req_t             mem_req;
    axi_resp_t            mem_resp;
    data_t                cd_data;
    logic                 cd_push;
    logic                 cd_full;

    port_data_t           port_data [NumCtrl];
    logic [NumCtrl-1:0]   gnt_taken = '0;
    int                   issued [NumCtrl];
    logic [31:0]          rng = Seed;
    int                   cycles = 0;
    int                   neg_cycles = 0;
    int                   granted = 0;
    int                   rr_next = 0;
    logic                 wb_wait = 1'b0;
    logic [MemIdW-1:0]    wb_wait_id;

    addr_item_t           exp_addr_q [$];
    w_chan_t              exp_w_q [$];
    data_t                exp_snoop_q [$];
    data_t                snoop_drive_q [$];
    data_t                exp_core_q [$];
    data_t                core_w_drive_q [$];
    logic [MemIdW-1:0]    aw_id_q [$];
    logic [MemIdW-1:0]    b_q [$];
    ar_chan_t             r_q [$];

    ccu_mem_top dut_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .mu_req_i    (mu_req),
        .mu_cmd_i    (mu_cmd),
        .mu_gnt_o    (mu_gnt),
        .core_req_i  (core_req),
        .core_resp_o (core_resp),
        .mem_req_o   (mem_req),
        .mem_resp_i  (mem_resp),
        .cd_data_i   (cd_data),
        .cd_push_i   (cd_push),
        .cd_full_o   (cd_full)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic w_chan_t w_beat(input data_t data, input logic last);
        w_chan_t w;
        w.data = data;
        w.strb = '1;
        w.last = last;
        return w;
    endfunction

    // Memory fill pattern built from the full address
    function automatic r_chan_t read_beat(input ar_chan_t ar);
        r_chan_t r;
        r.id   = ar.id;
        r.data = {ar.addr, ~ar.addr};
        r.resp = 2'b00;
        r.last = 1'b1;
        return r;
    endfunction

    // Expected address handshakes for one granted command
    function automatic addr_exp_t expected_addrs(input mu_cmd_t c);
        addr_exp_t              e;
        aw_chan_t               wb;
        logic                   from_ar;
        logic [`CCU_ADDR_W-1:0] src;
        e       = '0;
        from_ar = (c.op == SEND_WB_R);
        src     = from_ar ? c.ar.addr : c.aw.addr;
        wb      = '0;
        wb.id   = {1'b1, c.first_resp, from_ar ? c.ar.id[`CCU_ID_W-1:0] : c.aw.id[`CCU_ID_W-1:0]};
        wb.addr = src & ~(`CCU_ADDR_W'(`CCU_LINE_W / 8 - 1));
        wb.len  = 8'(`CCU_LINE_BEATS - 1);
        wb.size = 3'd3;
        wb.burst = BURST_INCR;
        e.n      = 2'd1;
        case (c.op)
            SEND_R: begin
                e.first.ar = c.ar;
            end
            SEND_W: begin
                e.first.is_aw = 1'b1;
                e.first.aw    = c.aw;
            end
            SEND_WB_R: begin
                e.first.is_aw  = 1'b1;
                e.first.aw     = wb;
                e.first.blocks = c.ar.lock;
                if (c.ar.lock) begin
                    e.n         = 2'd2;
                    e.second.ar = c.ar;
                end
            end
            default: begin
                e.n             = 2'd2;
                e.first.is_aw   = 1'b1;
                e.first.aw      = wb;
                e.first.blocks  = c.aw.atop[5];
                e.second.is_aw  = 1'b1;
                e.second.aw     = c.aw;
            end
        endcase
        return e;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error at %0t: %s is %0h, expected %0h",
                                $time, name, got, exp));
        end
    endtask

    task automatic make_command(output mu_cmd_t c, output port_data_t d);
        logic [31:0] r;
        r            = next_rand();
        c            = '0;
        c.op         = mu_op_e'(3'(r[1:0]));
        c.first_resp = IdxW'(r[3:2]);
        c.ar.id      = MemIdW'(r[7:4]);
        c.ar.addr    = next_rand();
        c.ar.size    = 3'd3;
        c.ar.burst   = BURST_INCR;
        c.ar.lock    = r[8];
        c.aw.id      = MemIdW'(r[12:9]);
        c.aw.addr    = next_rand();
        c.aw.size    = 3'd3;
        c.aw.burst   = BURST_INCR;
        c.aw.atop    = {r[13], 5'b0};
        d.wdata      = {next_rand(), next_rand()};
        d.snoop0     = {next_rand(), next_rand()};
        d.snoop1     = {next_rand(), next_rand()};
    endtask

    initial begin
        rst_ni           = 1'b0;
        mu_req           = '0;
        core_req         = '0;
        core_req.b_ready = 1'b1;
        core_req.r_ready = 1'b1;
        mem_resp         = '0;
        cd_data          = '0;
        cd_push          = 1'b0;
        foreach (mu_cmd[i]) begin
            mu_cmd[i]    = '0;
            port_data[i] = '0;
            issued[i]    = 0;
        end
    end

    // All inputs change on the falling edge
    always @(negedge clk_i) begin
        logic [31:0] r;
        if (neg_cycles < ResetCycles) begin
            neg_cycles++;
            if (neg_cycles == ResetCycles) begin
                check_value("mu_gnt_o", mu_gnt, '0);
                check_value("mem_req_o.ar_valid", mem_req.ar_valid, 1'b0);
                check_value("mem_req_o.aw_valid", mem_req.aw_valid, 1'b0);
                check_value("mem_req_o.w_valid", mem_req.w_valid, 1'b0);
                check_value("core_resp_o.b_valid", core_resp.b_valid, 1'b0);
                check_value("cd_full_o", cd_full, 1'b0);
                rst_ni = 1'b1;
            end
        end
        if (rst_ni) begin
            for (int i = 0; i < NumCtrl; i++) begin
                if (!mu_req[i] || gnt_taken[i]) begin
                    gnt_taken[i] = 1'b0;
                    mu_req[i]    = 1'b0;
                    if (issued[i] < CmdsPerPort) begin
                        make_command(mu_cmd[i], port_data[i]);
                        mu_req[i] = 1'b1;
                        issued[i]++;
                    end
                end
            end
            r                 = next_rand();
            mem_resp          = '0;
            mem_resp.aw_ready = r[0] | r[1];
            mem_resp.w_ready  = r[2] | r[3];
            mem_resp.ar_ready = r[4] | r[5];
            core_req.b_ready  = r[6] | r[7];
            core_req.r_ready  = r[8] | r[9];
            if (b_q.size() != 0) begin
                mem_resp.b_valid = 1'b1;
                mem_resp.b.id    = b_q[0];
            end
            if (r_q.size() != 0) begin
                mem_resp.r_valid = 1'b1;
                mem_resp.r       = read_beat(r_q[0]);
            end
            core_req.w_valid = (core_w_drive_q.size() != 0);
            if (core_w_drive_q.size() != 0) begin
                core_req.w = w_beat(core_w_drive_q[0], 1'b1);
            end
            cd_push = 1'b0;
            if (!cd_full && snoop_drive_q.size() != 0) begin
                cd_push = 1'b1;
                cd_data = snoop_drive_q.pop_front();
            end
        end
    end

    task automatic record_grant();
        addr_exp_t          e;
        int                 win;
        int                 idx;
        logic [NumCtrl-1:0] exp_gnt;
        if (exp_addr_q.size() == 0 && mu_req != '0) begin
            check_value("mu_gnt_o reduction or", |mu_gnt, 1'b1);
        end
        if (mu_gnt != '0) begin
            if (exp_addr_q.size() != 0) begin
                abort_run("Grant given while an address of the previous command was pending");
            end
            win = -1;
            for (int i = 0; i < NumCtrl; i++) begin
                idx = (rr_next + i) % NumCtrl;
                if (win < 0 && mu_req[idx]) begin
                    win = idx;
                end
            end
            if (win < 0) begin
                abort_run("Grant given while no controller port was requesting");
            end
            exp_gnt      = '0;
            exp_gnt[win] = 1'b1;
            check_value("mu_gnt_o", mu_gnt, exp_gnt);
            rr_next = (win + 1) % NumCtrl;
            e = expected_addrs(mu_cmd[win]);
            exp_addr_q.push_back(e.first);
            if (e.n == 2'd2) begin
                exp_addr_q.push_back(e.second);
            end
            if (mu_cmd[win].op == SEND_WB_R || mu_cmd[win].op == SEND_WB_W) begin
                exp_snoop_q.push_back(port_data[win].snoop0);
                exp_snoop_q.push_back(port_data[win].snoop1);
                snoop_drive_q.push_back(port_data[win].snoop0);
                snoop_drive_q.push_back(port_data[win].snoop1);
            end
            if (mu_cmd[win].op == SEND_W || mu_cmd[win].op == SEND_WB_W) begin
                exp_core_q.push_back(port_data[win].wdata);
                core_w_drive_q.push_back(port_data[win].wdata);
            end
            gnt_taken[win] = 1'b1;
            granted++;
        end
    endtask

    task automatic compare_address();
        addr_item_t item;
        if (mem_req.aw_valid && mem_resp.aw_ready) begin
            if (exp_addr_q.size() == 0 || wb_wait) begin
                abort_run("AW handshake on the memory bus that no command expected");
            end
            item = exp_addr_q.pop_front();
            check_value("address channel is AW", item.is_aw, 1'b1);
            check_value("mem_req_o.aw", mem_req.aw, item.aw);
            if (item.blocks) begin
                wb_wait    = 1'b1;
                wb_wait_id = item.aw.id;
            end
            aw_id_q.push_back(item.aw.id);
            if (item.aw.id[WbFlagBit]) begin
                exp_w_q.push_back(w_beat(exp_snoop_q.pop_front(), 1'b0));
                exp_w_q.push_back(w_beat(exp_snoop_q.pop_front(), 1'b1));
            end else begin
                exp_w_q.push_back(w_beat(exp_core_q.pop_front(), 1'b1));
            end
        end
        if (mem_req.ar_valid && mem_resp.ar_ready) begin
            if (exp_addr_q.size() == 0 || wb_wait) begin
                abort_run("AR handshake on the memory bus that no command expected");
            end
            item = exp_addr_q.pop_front();
            check_value("address channel is AW", item.is_aw, 1'b0);
            check_value("mem_req_o.ar", mem_req.ar, item.ar);
            r_q.push_back(item.ar);
        end
    endtask

    task automatic score_responses();
        logic [MemIdW-1:0] id;
        if (mem_req.w_valid && mem_resp.w_ready) begin
            if (exp_w_q.size() == 0) begin
                abort_run("W beat on the memory bus before its AW was accepted");
            end
            check_value("mem_req_o.w", mem_req.w, exp_w_q.pop_front());
            if (mem_req.w.last) begin
                b_q.push_back(aw_id_q.pop_front());
            end
        end
        if (core_req.w_valid && core_resp.w_ready) begin
            void'(core_w_drive_q.pop_front());
        end
        if (core_resp.b_valid) begin
            check_value("core_resp_o.b.id writeback flag", core_resp.b.id[WbFlagBit], 1'b0);
        end
        if (mem_resp.b_valid) begin
            id = b_q[0];
            if (id[WbFlagBit]) begin
                check_value("mem_req_o.b_ready", mem_req.b_ready, 1'b1);
                check_value("core_resp_o.b_valid", core_resp.b_valid, 1'b0);
            end else begin
                check_value("mem_req_o.b_ready", mem_req.b_ready, core_req.b_ready);
                check_value("core_resp_o.b_valid", core_resp.b_valid, 1'b1);
                check_value("core_resp_o.b.id", core_resp.b.id, id);
            end
            if (mem_req.b_ready) begin
                void'(b_q.pop_front());
                if (wb_wait && id == wb_wait_id) begin
                    wb_wait = 1'b0;
                end
            end
        end
        if (mem_resp.r_valid) begin
            check_value("mem_req_o.r_ready", mem_req.r_ready, core_req.r_ready);
            check_value("core_resp_o.r_valid", core_resp.r_valid, 1'b1);
            check_value("core_resp_o.r", core_resp.r, read_beat(r_q[0]));
            if (mem_req.r_ready) begin
                void'(r_q.pop_front());
            end
        end
    endtask

    // Checks sample on the rising edge
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > Timeout) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d of %0d commands granted",
                                cycles, granted, NumCmds));
        end
        if (rst_ni) begin
            record_grant();
            compare_address();
            score_responses();
            if (granted == NumCmds && exp_addr_q.size() == 0 && exp_w_q.size() == 0 &&
                b_q.size() == 0 && r_q.size() == 0 && aw_id_q.size() == 0) begin
                $display("=== PASS ===");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

/* ccu_mem.f */
+incdir+include
hw/ccu_axi_pkg.sv
hw/ccu_ctrl_pkg.sv
hw/ccu_fifo.sv
hw/ccu_mem_arbiter.sv
hw/ccu_mem_unit.sv
hw/ccu_mem_top.sv
bench/ccu_mem_tb.sv
